// File: source/cpuPkg.sv
// Core shared definitions
package cpuPkg;

	localparam int DataWidth = 32;
	localparam int RegCount = 32;

	typedef logic [DataWidth-1:0] wordT;
	typedef logic [4:0] regAddrT;

	typedef enum logic [5:0] {
		OpAlu  = 6'b00_0000,
		OpAddi = 6'b00_0001,
		OpBeq  = 6'b00_0100,
		OpLw   = 6'b01_0100,
		OpSw   = 6'b01_0101,
		OpNop  = 6'b11_1110,
		OpHalt = 6'b11_1111
	} opcodeT;

	// Register-register function lives in instruction bits 1..0
	typedef enum logic [1:0] {
		AluAdd = 2'd0,
		AluSub = 2'd1,
		AluAnd = 2'd2,
		AluOr  = 2'd3
	} aluOpT;

	typedef enum logic [1:0] {
		FwdNone = 2'd0,
		FwdMem  = 2'd1,
		FwdWb   = 2'd2
	} fwdSelT;

	typedef struct packed {
		logic valid;
		aluOpT aluOp;
		logic useImm;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isHalt;
		logic regWrite;
		regAddrT destReg;
		regAddrT srcA;
		regAddrT srcB;
		wordT srcAVal;
		wordT srcBVal;
		wordT imm;
		wordT nextPc;
	} idExT;

	typedef struct packed {
		logic valid;
		logic isLoad;
		logic isStore;
		logic isHalt;
		logic regWrite;
		regAddrT destReg;
		wordT result;
		wordT storeData;
		logic branchTaken;
		wordT branchTarget;
	} exMemT;

	typedef struct packed {
		logic en;
		regAddrT addr;
		wordT data;
	} regWriteT;

	typedef struct packed {
		logic valid;
		wordT addr;
	} instrReqT;

	typedef struct packed {
		logic valid;
		logic write;
		wordT addr;
		wordT wrData;
	} dataReqT;

endpackage

// File: source/fetchUnit.sv
// Instruction fetch stage
`timescale 1ns/1ns

module fetchUnit import cpuPkg::*; #(
	parameter wordT ResetPc = '0
) (
	input logic clk,
	input logic rst_n,
	input logic fullStall,
	input logic semiStall,
	input logic redirect,
	input wordT redirectPc,
	input logic halted,
	input wordT instrData,
	output instrReqT instrReq,
	output wordT ifInstr,
	output wordT ifNextPc,
	output logic ifValid
);

	wordT pc;
	wordT pcPlus4;

	assign pcPlus4 = pc + wordT'(4);

	// Request stays up on the current PC until halted
	assign instrReq.valid = !halted;
	assign instrReq.addr = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= ResetPc;
			ifValid <= 1'b0;
			ifInstr <= {OpNop, 26'd0};
			ifNextPc <= ResetPc;
		end else if (!fullStall) begin
			if (redirect) begin
				// Taken branch, drop the instruction in flight
				pc <= redirectPc;
				ifValid <= 1'b0;
			end else if (halted) begin
				ifValid <= 1'b0;
			end else if (!semiStall) begin
				pc <= pcPlus4;
				ifValid <= 1'b1;
				ifInstr <= instrData;
				ifNextPc <= pcPlus4;
			end
		end
	end

endmodule

// File: source/decodeUnit.sv
// Instruction decode and register file
`timescale 1ns/1ns

module decodeUnit import cpuPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic fullStall,
	input logic semiStall,
	input logic flush,
	input wordT ifInstr,
	input wordT ifNextPc,
	input logic ifValid,
	input regWriteT wbWrite,
	output idExT idEx,
	output regAddrT idSrcA,
	output regAddrT idSrcB
);

	wordT regFile [RegCount];
	idExT dec;
	regAddrT rdField;
	regAddrT rsField;

	assign rdField = ifInstr[25:21];
	assign rsField = ifInstr[20:16];

	// Same-cycle writeback bypasses the array
	function automatic wordT readReg(regAddrT addr);
		wordT value;
		if (addr == '0) begin
			value = '0;
		end else if (wbWrite.en && wbWrite.addr == addr) begin
			value = wbWrite.data;
		end else begin
			value = regFile[addr];
		end
		return value;
	endfunction

	always_comb begin
		dec = '0;
		dec.valid = ifValid;
		dec.aluOp = AluAdd;
		dec.destReg = rdField;
		dec.imm = {{(DataWidth-16){ifInstr[15]}}, ifInstr[15:0]};
		dec.nextPc = ifNextPc;
		case (opcodeT'(ifInstr[31:26]))
			OpAlu: begin
				dec.aluOp = aluOpT'(ifInstr[1:0]);
				dec.regWrite = 1'b1;
				dec.srcA = rsField;
				dec.srcB = ifInstr[15:11];
			end
			OpAddi: begin
				dec.useImm = 1'b1;
				dec.regWrite = 1'b1;
				dec.srcA = rsField;
			end
			OpLw: begin
				dec.useImm = 1'b1;
				dec.isLoad = 1'b1;
				dec.regWrite = 1'b1;
				dec.srcA = rsField;
			end
			// Store data and branch compare use the rd field
			OpSw: begin
				dec.useImm = 1'b1;
				dec.isStore = 1'b1;
				dec.srcA = rsField;
				dec.srcB = rdField;
			end
			OpBeq: begin
				dec.isBranch = 1'b1;
				dec.srcA = rsField;
				dec.srcB = rdField;
			end
			OpHalt: dec.isHalt = 1'b1;
			default: ;
		endcase
		if (!ifValid) begin
			dec.srcA = '0;
			dec.srcB = '0;
		end
		dec.srcAVal = readReg(dec.srcA);
		dec.srcBVal = readReg(dec.srcB);
	end

	assign idSrcA = dec.srcA;
	assign idSrcB = dec.srcB;

	always_ff @(posedge clk) begin
		if (wbWrite.en && wbWrite.addr != '0) begin
			regFile[wbWrite.addr] <= wbWrite.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idEx <= '0;
		end else if (!fullStall) begin
			idEx <= dec;
			if (flush || semiStall) begin
				idEx.valid <= 1'b0;
			end
		end
	end

endmodule

// File: source/executeUnit.sv
// Execute stage with operand forwarding
`timescale 1ns/1ns

module executeUnit import cpuPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic fullStall,
	input logic flush,
	input idExT idEx,
	input fwdSelT fwdSelA,
	input fwdSelT fwdSelB,
	input wordT memFwd,
	input regWriteT wbWrite,
	output exMemT exMem
);

	wordT opA;
	wordT opB;
	wordT aluB;
	wordT aluOut;
	wordT branchTarget;
	logic branchTaken;

	function automatic wordT pickOperand(fwdSelT sel, wordT regVal, wordT memVal,
			wordT wbVal);
		wordT value;
		case (sel)
			FwdMem: value = memVal;
			FwdWb: value = wbVal;
			default: value = regVal;
		endcase
		return value;
	endfunction

	always_comb begin
		opA = pickOperand(fwdSelA, idEx.srcAVal, memFwd, wbWrite.data);
		opB = pickOperand(fwdSelB, idEx.srcBVal, memFwd, wbWrite.data);
		aluB = idEx.useImm ? idEx.imm : opB;
		case (idEx.aluOp)
			AluAdd: aluOut = opA + aluB;
			AluSub: aluOut = opA - aluB;
			AluAnd: aluOut = opA & aluB;
			default: aluOut = opA | aluB;
		endcase
		// Word offset from the next PC
		branchTarget = idEx.nextPc + (idEx.imm << 2);
		branchTaken = idEx.isBranch && (opA == opB);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem <= '0;
		end else if (!fullStall) begin
			exMem.valid <= idEx.valid && !flush;
			exMem.isLoad <= idEx.isLoad;
			exMem.isStore <= idEx.isStore;
			exMem.isHalt <= idEx.isHalt;
			exMem.regWrite <= idEx.regWrite;
			exMem.destReg <= idEx.destReg;
			exMem.result <= aluOut;
			exMem.storeData <= opB;
			exMem.branchTaken <= branchTaken;
			exMem.branchTarget <= branchTarget;
		end
	end

endmodule

// File: source/memoryUnit.sv
// Memory access and writeback stage
`timescale 1ns/1ns

module memoryUnit import cpuPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic fullStall,
	input exMemT exMem,
	input wordT dataRdData,
	output dataReqT dataReq,
	output wordT memFwd,
	output regWriteT wbWrite,
	output logic redirect,
	output wordT redirectPc,
	output logic flush,
	output logic halted
);

	logic live;

	// Nothing past a retired halt may touch state
	assign live = exMem.valid && !halted;

	assign dataReq.valid = live && (exMem.isLoad || exMem.isStore);
	assign dataReq.write = exMem.isStore;
	assign dataReq.addr = exMem.result;
	assign dataReq.wrData = exMem.storeData;

	assign memFwd = exMem.result;

	// Not-taken is assumed, so a taken branch squashes the three younger slots
	assign redirect = live && exMem.branchTaken;
	assign redirectPc = exMem.branchTarget;
	assign flush = redirect;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbWrite <= '0;
			halted <= 1'b0;
		end else if (!fullStall) begin
			wbWrite.en <= live && exMem.regWrite;
			wbWrite.addr <= exMem.destReg;
			wbWrite.data <= exMem.isLoad ? dataRdData : exMem.result;
			if (live && exMem.isHalt) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

// File: source/hazardUnit.sv
// Forwarding and stall control
`timescale 1ns/1ns

module hazardUnit import cpuPkg::*; (
	input regAddrT idSrcA,
	input regAddrT idSrcB,
	input idExT idEx,
	input exMemT exMem,
	input regWriteT wbWrite,
	input instrReqT instrReq,
	input logic instrReady,
	input dataReqT dataReq,
	input logic dataReady,
	output fwdSelT fwdSelA,
	output fwdSelT fwdSelB,
	output logic fullStall,
	output logic semiStall
);

	logic loadInEx;

	// Youngest producer wins
	function automatic fwdSelT pickSource(regAddrT src, exMemT memStage, regWriteT wbStage);
		fwdSelT sel;
		if (src == '0) begin
			sel = FwdNone;
		end else if (memStage.valid && memStage.regWrite && memStage.destReg == src) begin
			sel = FwdMem;
		end else if (wbStage.en && wbStage.addr == src) begin
			sel = FwdWb;
		end else begin
			sel = FwdNone;
		end
		return sel;
	endfunction

	assign fwdSelA = pickSource(idEx.srcA, exMem, wbWrite);
	assign fwdSelB = pickSource(idEx.srcB, exMem, wbWrite);

	// Load result is one stage too late for the next instruction
	assign loadInEx = idEx.valid && idEx.isLoad && idEx.destReg != '0;
	assign semiStall = loadInEx && (idEx.destReg == idSrcA || idEx.destReg == idSrcB);

	assign fullStall = (instrReq.valid && !instrReady) || (dataReq.valid && !dataReady);

endmodule

// File: source/pipeCpu.sv
// Five-stage pipelined core
`timescale 1ns/1ns

module pipeCpu import cpuPkg::*; #(
	parameter wordT ResetPc = '0
) (
	input logic clk,
	input logic rst_n,
	input wordT instrData,
	input logic instrReady,
	input wordT dataRdData,
	input logic dataReady,
	output instrReqT instrReq,
	output dataReqT dataReq,
	output logic halt
);

	wordT ifInstr;
	wordT ifNextPc;
	logic ifValid;
	idExT idEx;
	regAddrT idSrcA;
	regAddrT idSrcB;
	exMemT exMem;
	regWriteT wbWrite;
	wordT memFwd;
	wordT redirectPc;
	logic redirect;
	logic flush;
	logic fullStall;
	logic semiStall;
	fwdSelT fwdSelA;
	fwdSelT fwdSelB;

	fetchUnit #(
		.ResetPc(ResetPc)
	) fetch (
		.clk(clk),
		.rst_n(rst_n),
		.fullStall(fullStall),
		.semiStall(semiStall),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.halted(halt),
		.instrData(instrData),
		.instrReq(instrReq),
		.ifInstr(ifInstr),
		.ifNextPc(ifNextPc),
		.ifValid(ifValid)
	);

	decodeUnit decode (
		.clk(clk),
		.rst_n(rst_n),
		.fullStall(fullStall),
		.semiStall(semiStall),
		.flush(flush),
		.ifInstr(ifInstr),
		.ifNextPc(ifNextPc),
		.ifValid(ifValid),
		.wbWrite(wbWrite),
		.idEx(idEx),
		.idSrcA(idSrcA),
		.idSrcB(idSrcB)
	);

	executeUnit execute (
		.clk(clk),
		.rst_n(rst_n),
		.fullStall(fullStall),
		.flush(flush),
		.idEx(idEx),
		.fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB),
		.memFwd(memFwd),
		.wbWrite(wbWrite),
		.exMem(exMem)
	);

	memoryUnit memory (
		.clk(clk),
		.rst_n(rst_n),
		.fullStall(fullStall),
		.exMem(exMem),
		.dataRdData(dataRdData),
		.dataReq(dataReq),
		.memFwd(memFwd),
		.wbWrite(wbWrite),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.flush(flush),
		.halted(halt)
	);

	hazardUnit hazard (
		.idSrcA(idSrcA),
		.idSrcB(idSrcB),
		.idEx(idEx),
		.exMem(exMem),
		.wbWrite(wbWrite),
		.instrReq(instrReq),
		.instrReady(instrReady),
		.dataReq(dataReq),
		.dataReady(dataReady),
		.fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB),
		.fullStall(fullStall),
		.semiStall(semiStall)
	);

endmodule

// File: testbench/tbMemory.sv
// Instruction and data memory model
`timescale 1ns/1ns

module tbMemory import cpuPkg::*; #(
	parameter int Words = 64
) (
	input logic clk,
	input logic rst_n,
	input logic delayOn,
	input instrReqT instrReq,
	input dataReqT dataReq,
	output wordT instrData,
	output logic instrReady,
	output wordT dataRdData,
	output logic dataReady
);

	localparam int IdxTop = $clog2(Words) + 1;

	wordT imem [Words];
	wordT dmem [Words];
	integer seed = 32'h4462607f;
	int i;

	assign instrData = imem[instrReq.addr[IdxTop:2]];
	assign dataRdData = dmem[dataReq.addr[IdxTop:2]];

	initial begin
		instrReady = 1'b1;
		dataReady = 1'b1;
	end

	// Fresh coin toss per port each cycle
	always @(posedge clk) begin
		if (delayOn) begin
			instrReady <= ($random(seed) & 3) != 0;
			dataReady <= ($random(seed) & 3) != 0;
		end else begin
			instrReady <= 1'b1;
			dataReady <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			for (i = 0; i < Words; i++) begin
				dmem[i] <= (i * 32'h0101_0101) ^ 32'hc3a5_0f00;
			end
		end else if (dataReq.valid && dataReady && dataReq.write) begin
			dmem[dataReq.addr[IdxTop:2]] <= dataReq.wrData;
		end
	end

endmodule

// File: testbench/pipeCpuTb.sv
// Pipelined core testbench
`timescale 1ns/1ns

module pipeCpuTb import cpuPkg::*; ();

	localparam wordT ResetPc = 32'h0000_0020;
	localparam int MemWords = 64;
	localparam int Base = ResetPc / 4;
	localparam int WaitLimit = 3000;
	localparam wordT Marker = 32'h0000_7bad;

	logic clk;
	logic rst_n;
	logic delayOn;
	logic resetCmd;
	logic delayCmd;
	wordT instrData;
	logic instrReady;
	wordT dataRdData;
	logic dataReady;
	instrReqT instrReq;
	dataReqT dataReq;
	logic halt;

	wordT prog [MemWords];
	wordT model [MemWords];
	wordT expAddr [$];
	wordT expData [$];
	string runName;
	int storesSeen;
	logic haltSeen;
	logic prevStalled;
	dataReqT prevReq;

	pipeCpu #(
		.ResetPc(ResetPc)
	) uut (
		.clk(clk),
		.rst_n(rst_n),
		.instrData(instrData),
		.instrReady(instrReady),
		.dataRdData(dataRdData),
		.dataReady(dataReady),
		.instrReq(instrReq),
		.dataReq(dataReq),
		.halt(halt)
	);

	tbMemory #(
		.Words(MemWords)
	) memModel (
		.clk(clk),
		.rst_n(rst_n),
		.delayOn(delayOn),
		.instrReq(instrReq),
		.dataReq(dataReq),
		.instrData(instrData),
		.instrReady(instrReady),
		.dataRdData(dataRdData),
		.dataReady(dataReady)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Commands from the negedge process reach the DUT on the next rising edge
	always @(posedge clk) begin
		rst_n <= resetCmd;
		delayOn <= delayCmd;
	end

	function automatic wordT aluInstr(aluOpT op, regAddrT rd, regAddrT rs, regAddrT rt);
		return {OpAlu, rd, rs, rt, 9'd0, op};
	endfunction

	function automatic wordT immInstr(opcodeT op, regAddrT rd, regAddrT rs, logic [15:0] imm);
		return {op, rd, rs, imm};
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic valueError(input string name, input wordT expected, input wordT actual);
		failRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic loadProgram();
		int i;
		for (i = 0; i < MemWords; i++) begin
			prog[i] = {OpNop, 26'd0};
		end
		// Dependent ALU chain
		prog[Base + 0] = immInstr(OpAddi, 5'd1, 5'd0, 16'h005a);
		prog[Base + 1] = immInstr(OpAddi, 5'd2, 5'd1, 16'h0123);
		prog[Base + 2] = aluInstr(AluAdd, 5'd3, 5'd1, 5'd2);
		prog[Base + 3] = aluInstr(AluSub, 5'd4, 5'd1, 5'd3);
		prog[Base + 4] = aluInstr(AluAnd, 5'd5, 5'd4, 5'd3);
		prog[Base + 5] = aluInstr(AluOr, 5'd6, 5'd5, 5'd2);
		prog[Base + 6] = immInstr(OpAddi, 5'd7, 5'd0, 16'h0040);
		prog[Base + 7] = immInstr(OpSw, 5'd3, 5'd7, 16'h0000);
		prog[Base + 8] = immInstr(OpSw, 5'd4, 5'd7, 16'h0004);
		prog[Base + 9] = immInstr(OpSw, 5'd5, 5'd7, 16'h0008);
		prog[Base + 10] = immInstr(OpSw, 5'd6, 5'd7, 16'h000c);
		// Load then immediate use
		prog[Base + 11] = immInstr(OpLw, 5'd8, 5'd0, 16'h0010);
		prog[Base + 12] = aluInstr(AluAdd, 5'd9, 5'd8, 5'd1);
		prog[Base + 13] = immInstr(OpSw, 5'd9, 5'd7, 16'h0010);
		// Taken branch skips the marker store, the second one falls through
		prog[Base + 14] = immInstr(OpAddi, 5'd11, 5'd0, Marker[15:0]);
		prog[Base + 15] = immInstr(OpBeq, 5'd1, 5'd1, 16'h0001);
		prog[Base + 16] = immInstr(OpSw, 5'd11, 5'd7, 16'h0014);
		prog[Base + 17] = immInstr(OpBeq, 5'd1, 5'd2, 16'h0001);
		prog[Base + 18] = immInstr(OpSw, 5'd2, 5'd7, 16'h0018);
		prog[Base + 19] = {OpHalt, 26'd0};
		prog[Base + 20] = immInstr(OpSw, 5'd11, 5'd7, 16'h001c);
		for (i = 0; i < MemWords; i++) begin
			memModel.imem[i] = prog[i];
		end
	endtask

	// Instruction-level model of the program, one instruction at a time
	task automatic buildExpected();
		wordT regs [RegCount];
		wordT pc;
		wordT instr;
		wordT rsVal;
		wordT rdVal;
		wordT imm;
		wordT addr;
		wordT value;
		opcodeT op;
		int steps;
		regs = '{default: '0};
		expAddr.delete();
		expData.delete();
		pc = ResetPc;
		instr = prog[pc[7:2]];
		for (steps = 0; opcodeT'(instr[31:26]) != OpHalt; steps++) begin
			assert (steps < WaitLimit) else failRun("program model never reached halt");
			op = opcodeT'(instr[31:26]);
			rsVal = regs[instr[20:16]];
			rdVal = regs[instr[25:21]];
			imm = {{16{instr[15]}}, instr[15:0]};
			addr = rsVal + imm;
			value = '0;
			pc = pc + 32'd4;
			case (op)
				OpAlu: begin
					case (aluOpT'(instr[1:0]))
						AluAdd: value = rsVal + regs[instr[15:11]];
						AluSub: value = rsVal - regs[instr[15:11]];
						AluAnd: value = rsVal & regs[instr[15:11]];
						default: value = rsVal | regs[instr[15:11]];
					endcase
				end
				OpAddi: value = addr;
				OpLw: value = model[addr[7:2]];
				OpSw: begin
					expAddr.push_back(addr);
					expData.push_back(rdVal);
					model[addr[7:2]] = rdVal;
				end
				OpBeq: begin
					if (rsVal == rdVal) begin
						pc = pc + (imm << 2);
					end
				end
				default: ;
			endcase
			if ((op == OpAlu || op == OpAddi || op == OpLw) && instr[25:21] != 5'd0) begin
				regs[instr[25:21]] = value;
			end
			instr = prog[pc[7:2]];
		end
	endtask

	task automatic checkStore(input logic retires);
		string tag;
		tag = $sformatf("%s store %0d", runName, storesSeen);
		assert (dataReq.wrData != Marker)
			else failRun({tag, ": the skipped marker value reached the data port"});
		assert (expAddr.size() > 0) else failRun({tag, ": store not expected by the model"});
		assert (dataReq.addr == expAddr[0]) else valueError({tag, " address"}, expAddr[0],
			dataReq.addr);
		assert (dataReq.wrData == expData[0]) else valueError({tag, " data"}, expData[0],
			dataReq.wrData);
		// A waiting fetch freezes the pipeline, so the same store is presented again
		if (retires) begin
			void'(expAddr.pop_front());
			void'(expData.pop_front());
			storesSeen++;
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			haltSeen = 1'b0;
			prevStalled = 1'b0;
		end else begin
			if (dataReq.valid && dataReady && dataReq.write) begin
				checkStore(!(instrReq.valid && !instrReady));
			end
			if (prevStalled) begin
				assert (dataReq == prevReq)
					else failRun({runName, ": data request changed while waiting for ready"});
			end
			if (haltSeen) begin
				assert (halt) else failRun({runName, ": halt dropped before reset"});
			end
			if (halt) begin
				assert (!dataReq.valid) else failRun({runName, ": data request after halt"});
			end
			haltSeen = haltSeen || halt;
			prevStalled = dataReq.valid && !dataReady;
			prevReq = dataReq;
		end
	end

	task automatic runProgram(input string name, input logic delays);
		int cycles;
		int i;
		@(negedge clk);
		runName = name;
		resetCmd = 1'b0;
		delayCmd = delays;
		repeat (3) @(negedge clk);
		// Data memory is refilled during reset
		for (i = 0; i < MemWords; i++) begin
			model[i] = memModel.dmem[i];
		end
		buildExpected();
		resetCmd = 1'b1;
		@(negedge clk);
		assert (!halt) else failRun({name, ": halt is high after reset"});
		assert (!dataReq.valid) else failRun({name, ": data request valid after reset"});
		assert (instrReq.valid) else failRun({name, ": no instruction request after reset"});
		assert (instrReq.addr == ResetPc)
			else valueError({name, " first fetch address"}, ResetPc, instrReq.addr);
		cycles = 0;
		while (!halt) begin
			assert (cycles < WaitLimit) else failRun({name, ": timed out waiting for halt"});
			@(negedge clk);
			cycles++;
		end
		assert (!instrReq.valid) else failRun({name, ": instruction requests go on after halt"});
		repeat (8) @(negedge clk);
		assert (expAddr.size() == 0)
			else failRun($sformatf("%s: %0d expected stores never appeared", name, expAddr.size()));
	endtask

	initial begin
		rst_n = 1'b0;
		delayOn = 1'b0;
		resetCmd = 1'b0;
		delayCmd = 1'b0;
		storesSeen = 0;
		runName = "reset";
		loadProgram();
		runProgram("run without delays", 1'b0);
		runProgram("run with random ready delays", 1'b1);
		$display("test passed");
		$finish;
	end

endmodule

// File: pipeCpu.f
source/cpuPkg.sv
source/fetchUnit.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memoryUnit.sv
source/hazardUnit.sv
source/pipeCpu.sv
testbench/tbMemory.sv
testbench/pipeCpuTb.sv

// File: Makefile
VERILATOR = verilator
TOP = pipeCpuTb
FILELIST = pipeCpu.f
OBJDIR = obj_dir
LOG = sim.log
LINTFLAGS = --lint-only --timing
SIMFLAGS = --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
